// File: common/miner_pkg.sv
`default_nettype none

package miner_pkg;

    // playfield geometry in pixels
    localparam int field_w     = 10;
    localparam int field_x_max = 320;
    localparam int field_y_max = 240;
    localparam int item_size   = 16;

    // rope limits, lengths in pixels and angles in degrees
    localparam int rope_min_len = 20;
    localparam int swing_lo     = 15;
    localparam int swing_hi     = 165;
    localparam int delta_len    = 5;

    // points per item kind
    localparam int score_stone   = 10;
    localparam int score_gold    = 20;
    localparam int score_diamond = 50;

    typedef logic [3:0] item_idx_t;

    typedef enum logic [1:0] {
        kind_stone   = 2'd0,
        kind_gold    = 2'd1,
        kind_diamond = 2'd2
    } item_kind_t;

    // top-left corner of the 16x16 box, plus state flags
    typedef struct packed {
        logic [field_w-1:0] x;
        logic [field_w-1:0] y;
        item_kind_t         kind;
        logic               visible;
        logic               taken;
    } item_t;

    typedef struct packed {
        item_idx_t  index;
        item_kind_t kind;
    } catch_t;

    function automatic logic [7:0] score_of(item_kind_t kind);
        case (kind)
            kind_gold:    return 8'(score_gold);
            kind_diamond: return 8'(score_diamond);
            default:      return 8'(score_stone);
        endcase
    endfunction

endpackage

`default_nettype wire

// File: common/catch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface catch_if (
    input wire clock
);

    // four-phase: req up, ack up, req down, ack down
    logic              req;
    logic              ack;
    miner_pkg::catch_t rec;

    modport producer (
        input  clock,
        input  ack,
        output req,
        output rec
    );

    modport buffer (
        input  clock,
        input  req,
        input  rec,
        output ack
    );

endinterface

`default_nettype wire

// File: rope/angle_trig.sv
`timescale 1ns/1ps
`default_nettype none

module angle_trig (
    input  wire logic [miner_pkg::field_w-1:0] angle,
    output logic [8:0]                         sin_val,
    output logic [8:0]                         cos_val,
    output logic                               cos_neg
);

    // quarter-wave sine by whole degree, 256 is 1.0
    localparam logic [8:0] sin_tab [0:90] = '{
          0,   4,   9,  13,  18,  22,  27,  31,  36,  40,
         44,  49,  53,  58,  62,  66,  71,  75,  79,  83,
         88,  92,  96, 100, 104, 108, 112, 116, 120, 124,
        128, 132, 136, 139, 143, 147, 150, 154, 158, 161,
        165, 168, 171, 175, 178, 181, 184, 187, 190, 193,
        196, 199, 202, 204, 207, 210, 212, 215, 217, 219,
        222, 224, 226, 228, 230, 232, 234, 236, 237, 239,
        241, 242, 243, 245, 246, 247, 248, 249, 250, 251,
        252, 253, 254, 254, 255, 255, 255, 256, 256, 256,
        256
    };

    logic [6:0] fold;

    // mirror the second quadrant back onto the first
    always_comb begin
        if (angle >= 10'd180) begin
            fold = 7'd0;
        end else if (angle > 10'd90) begin
            fold = 7'(10'd180 - angle);
        end else begin
            fold = 7'(angle);
        end
    end

    assign sin_val = sin_tab[fold];
    assign cos_val = sin_tab[7'd90 - fold];
    assign cos_neg = (angle > 10'd90);

endmodule

`default_nettype wire

// File: rope/rope_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rope_ctrl #(
    parameter int frame_cycles = 833334
) (
    input  wire                                        clock,
    input  wire                                        resetn,
    input  wire                                        enable,
    input  wire                                        launch,
    input  wire logic [$bits(miner_pkg::item_idx_t):0] item_count,
    output miner_pkg::item_idx_t                       rd_index,
    input  wire miner_pkg::item_t                      rd_item,
    output logic                                       mark_en,
    output miner_pkg::item_idx_t                       mark_index,
    output logic                                       mark_hide,
    catch_if.producer                                  catch_out,
    output logic [miner_pkg::field_w-1:0]              angle,
    output logic [miner_pkg::field_w-1:0]              rope_len
);

    localparam int fw       = miner_pkg::field_w;
    localparam int idx_w    = $bits(miner_pkg::item_idx_t);
    localparam int cnt_w    = $clog2(frame_cycles + 1);
    localparam int origin_x = 160;
    localparam int origin_y = 45;

    localparam logic [fw-1:0] len_min  = fw'(miner_pkg::rope_min_len);
    localparam logic [fw-1:0] len_step = fw'(miner_pkg::delta_len);
    localparam logic [fw-1:0] ang_lo   = fw'(miner_pkg::swing_lo);
    localparam logic [fw-1:0] ang_hi   = fw'(miner_pkg::swing_hi);
    localparam logic [fw-1:0] ang_rest = fw'(90);

    typedef enum logic [3:0] {
        s_idle,
        s_swing_left,
        s_swing_right,
        s_launch_wait,
        s_extend,
        s_scan_start,
        s_scan_addr,
        s_scan_check,
        s_retract,
        s_hide,
        s_handoff,
        s_release
    } state_t;

    state_t               state;
    state_t               resume;
    logic [cnt_w-1:0]     frame_cnt;
    logic                 tick;
    logic                 was_right;
    logic                 carrying;
    logic                 req;
    miner_pkg::item_idx_t scan_idx;
    logic [idx_w:0]       next_idx;
    miner_pkg::catch_t    caught;
    logic [8:0]           sin_val;
    logic [8:0]           cos_val;
    logic                 cos_neg;
    logic [18:0]          dx_full;
    logic [18:0]          dy_full;
    logic signed [11:0]   dx;
    logic signed [11:0]   dy;
    logic signed [11:0]   tip_x;
    logic signed [11:0]   tip_y;
    logic signed [11:0]   item_x;
    logic signed [11:0]   item_y;
    logic                 out_of_field;
    logic                 hit;

    angle_trig u_trig (
        .angle   (angle),
        .sin_val (sin_val),
        .cos_val (cos_val),
        .cos_neg (cos_neg)
    );

    // frame tick, frozen while enable is low
    always_ff @(posedge clock) begin
        if (!resetn) begin
            frame_cnt <= '0;
        end else if (tick) begin
            frame_cnt <= '0;
        end else if (enable) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign tick = enable && (frame_cnt == cnt_w'(frame_cycles - 1));

    // tip position from origin, length and angle
    assign dx_full = rope_len * cos_val;
    assign dy_full = rope_len * sin_val;
    assign dx      = {1'b0, dx_full[18:8]};
    assign dy      = {1'b0, dy_full[18:8]};
    assign tip_x   = cos_neg ? 12'(origin_x) - dx : 12'(origin_x) + dx;
    assign tip_y   = 12'(origin_y) + dy;

    assign out_of_field = (tip_x < 0) || (tip_x >= miner_pkg::field_x_max) ||
                          (tip_y >= miner_pkg::field_y_max);

    assign item_x = {2'b00, rd_item.x};
    assign item_y = {2'b00, rd_item.y};
    assign hit    = rd_item.visible && !rd_item.taken &&
                    (item_x < tip_x) && (tip_x <= item_x + miner_pkg::item_size) &&
                    (item_y < tip_y) && (tip_y <= item_y + miner_pkg::item_size);

    assign next_idx = {1'b0, scan_idx} + 1'b1;
    assign resume   = was_right ? s_swing_right : s_swing_left;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= s_idle;
            angle     <= ang_rest;
            rope_len  <= len_min;
            was_right <= 1'b0;
            carrying  <= 1'b0;
            req       <= 1'b0;
            scan_idx  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (enable) begin
                        state <= s_swing_left;
                    end
                end
                s_swing_left, s_swing_right: begin
                    if (launch) begin
                        was_right <= (state == s_swing_right);
                        state     <= s_launch_wait;
                    end else if (tick && state == s_swing_left) begin
                        if (angle == ang_lo) begin
                            angle <= angle + 1'b1;
                            state <= s_swing_right;
                        end else begin
                            angle <= angle - 1'b1;
                        end
                    end else if (tick) begin
                        if (angle == ang_hi) begin
                            angle <= angle - 1'b1;
                            state <= s_swing_left;
                        end else begin
                            angle <= angle + 1'b1;
                        end
                    end
                end
                s_launch_wait, s_extend: begin
                    if (tick) begin
                        rope_len <= rope_len + len_step;
                        state    <= s_scan_start;
                    end
                end
                s_scan_start: begin
                    scan_idx <= '0;
                    if (out_of_field) begin
                        state <= s_retract;
                    end else if (item_count == '0) begin
                        state <= s_extend;
                    end else begin
                        state <= s_scan_addr;
                    end
                end
                // table read data arrives one cycle after the address
                s_scan_addr: begin
                    state <= s_scan_check;
                end
                s_scan_check: begin
                    if (hit) begin
                        caught.index <= scan_idx;
                        caught.kind  <= rd_item.kind;
                        carrying     <= 1'b1;
                        state        <= s_retract;
                    end else if (next_idx >= item_count) begin
                        state <= s_extend;
                    end else begin
                        scan_idx <= next_idx[idx_w-1:0];
                        state    <= s_scan_addr;
                    end
                end
                s_retract: begin
                    if (tick && rope_len <= len_min + len_step) begin
                        rope_len <= len_min;
                        state    <= carrying ? s_hide : resume;
                    end else if (tick) begin
                        rope_len <= rope_len - len_step;
                    end
                end
                s_hide: begin
                    req   <= 1'b1;
                    state <= s_handoff;
                end
                // stalls here while the FIFO is full
                s_handoff: begin
                    if (catch_out.ack) begin
                        req   <= 1'b0;
                        state <= s_release;
                    end
                end
                s_release: begin
                    if (!catch_out.ack) begin
                        carrying <= 1'b0;
                        state    <= resume;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    assign rd_index   = scan_idx;
    assign mark_en    = (state == s_scan_check && hit) || (state == s_hide);
    assign mark_hide  = (state == s_hide);
    assign mark_index = (state == s_hide) ? caught.index : scan_idx;

    assign catch_out.req = req;
    assign catch_out.rec = caught;

endmodule

`default_nettype wire

// File: design/item_table.sv
`timescale 1ns/1ps
`default_nettype none

module item_table (
    input  wire                        clock,
    input  wire                        resetn,
    input  wire                        load_en,
    input  wire miner_pkg::item_idx_t  load_index,
    input  wire miner_pkg::item_t      load_item,
    input  wire miner_pkg::item_idx_t  rd_index,
    output miner_pkg::item_t           rd_item,
    input  wire                        mark_en,
    input  wire miner_pkg::item_idx_t  mark_index,
    input  wire                        mark_hide
);

    miner_pkg::item_t mem [16];

    // only the visible flags are cleared, positions stay as loaded
    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < 16; i++) begin
                mem[i].visible <= 1'b0;
            end
        end else begin
            if (load_en) begin
                mem[load_index] <= load_item;
            end
            if (mark_en && mark_hide) begin
                mem[mark_index].visible <= 1'b0;
            end else if (mark_en) begin
                mem[mark_index].taken <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        rd_item <= mem[rd_index];
    end

endmodule

`default_nettype wire

// File: design/catch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module catch_fifo #(
    parameter type payload_t = miner_pkg::catch_t,
    parameter int  depth     = 4
) (
    input  wire     clock,
    input  wire     resetn,
    catch_if.buffer in_port,
    output logic    out_valid,
    output payload_t out_data,
    input  wire     out_ready
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   fill;
    logic             ack;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (fill == depth);

    // a new record is taken only while ack is low, so one req stores once
    assign push = in_port.req && !ack && !full;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            ack    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
                ack    <= 1'b1;
            end else if (ack && !in_port.req) begin
                ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_port.rec;
        end
    end

    assign in_port.ack = ack;
    assign out_valid   = (fill != '0);
    assign out_data    = mem[rd_ptr];

endmodule

`default_nettype wire

// File: design/score_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module score_keeper (
    input  wire                     clock,
    input  wire                     resetn,
    input  wire                     pause,
    input  wire                     in_valid,
    input  wire miner_pkg::catch_t  in_data,
    output logic                    in_ready,
    output logic [15:0]             score,
    output logic [7:0]              catch_count
);

    // pause stalls the queue behind us
    assign in_ready = !pause;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            score       <= '0;
            catch_count <= '0;
        end else if (in_valid && in_ready) begin
            score       <= score + 16'(miner_pkg::score_of(in_data.kind));
            catch_count <= catch_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/miner_top.sv
`timescale 1ns/1ps
`default_nettype none

module miner_top #(
    parameter int frame_cycles = 8
) (
    input  wire                                        clock,
    input  wire                                        resetn,
    input  wire                                        enable,
    input  wire                                        launch,
    input  wire                                        load_en,
    input  wire miner_pkg::item_idx_t                  load_index,
    input  wire miner_pkg::item_t                      load_item,
    input  wire logic [$bits(miner_pkg::item_idx_t):0] item_count,
    input  wire                                        pause,
    output logic [miner_pkg::field_w-1:0]              angle,
    output logic [miner_pkg::field_w-1:0]              rope_len,
    output logic [15:0]                                score,
    output logic [7:0]                                 catch_count,
    output logic                                       item_visible
);

    localparam int catch_depth = 4;

    miner_pkg::item_idx_t rope_rd_index;
    miner_pkg::item_idx_t tab_rd_index;
    miner_pkg::item_t     tab_rd_item;
    logic                 mark_en;
    miner_pkg::item_idx_t mark_index;
    logic                 mark_hide;
    logic                 fifo_valid;
    miner_pkg::catch_t    fifo_data;
    logic                 score_ready;

    catch_if u_catch_if (
        .clock (clock)
    );

    // the rope only scans once it has left the top, so at rest the
    // load index can borrow the read port for visibility checks
    assign tab_rd_index = (rope_len == miner_pkg::rope_min_len) ? load_index : rope_rd_index;
    assign item_visible = tab_rd_item.visible;

    item_table u_items (
        .clock      (clock),
        .resetn     (resetn),
        .load_en    (load_en),
        .load_index (load_index),
        .load_item  (load_item),
        .rd_index   (tab_rd_index),
        .rd_item    (tab_rd_item),
        .mark_en    (mark_en),
        .mark_index (mark_index),
        .mark_hide  (mark_hide)
    );

    rope_ctrl #(
        .frame_cycles (frame_cycles)
    ) u_rope (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .launch     (launch),
        .item_count (item_count),
        .rd_index   (rope_rd_index),
        .rd_item    (tab_rd_item),
        .mark_en    (mark_en),
        .mark_index (mark_index),
        .mark_hide  (mark_hide),
        .catch_out  (u_catch_if.producer),
        .angle      (angle),
        .rope_len   (rope_len)
    );

    catch_fifo #(
        .payload_t (miner_pkg::catch_t),
        .depth     (catch_depth)
    ) u_fifo (
        .clock     (clock),
        .resetn    (resetn),
        .in_port   (u_catch_if.buffer),
        .out_valid (fifo_valid),
        .out_data  (fifo_data),
        .out_ready (score_ready)
    );

    score_keeper u_score (
        .clock       (clock),
        .resetn      (resetn),
        .pause       (pause),
        .in_valid    (fifo_valid),
        .in_data     (fifo_data),
        .in_ready    (score_ready),
        .score       (score),
        .catch_count (catch_count)
    );

endmodule

`default_nettype wire

// File: verif/miner_chk.sv
`timescale 1ns/1ps
`default_nettype none

module miner_chk (
    input wire                                clock,
    input wire                                resetn,
    input wire                                req,
    input wire                                ack,
    input wire miner_pkg::catch_t             rec,
    input wire logic [miner_pkg::field_w-1:0] angle,
    input wire logic [miner_pkg::field_w-1:0] rope_len
);

    localparam int fw = miner_pkg::field_w;

    // four-phase producer side
    req_held: assert property (@(posedge clock) disable iff (!resetn)
        req && !ack |=> req)
        else $error("req dropped before ack");

    rec_stable: assert property (@(posedge clock) disable iff (!resetn)
        req && $past(req) |-> rec == $past(rec))
        else $error("catch record changed while req was high");

    angle_range: assert property (@(posedge clock) disable iff (!resetn)
        angle >= fw'(miner_pkg::swing_lo) && angle <= fw'(miner_pkg::swing_hi))
        else $error("rope angle outside the swing range");

    len_floor: assert property (@(posedge clock) disable iff (!resetn)
        rope_len >= fw'(miner_pkg::rope_min_len))
        else $error("rope shorter than its minimum length");

endmodule

bind rope_ctrl miner_chk u_chk (
    .clock    (clock),
    .resetn   (resetn),
    .req      (req),
    .ack      (catch_out.ack),
    .rec      (caught),
    .angle    (angle),
    .rope_len (rope_len)
);

`default_nettype wire

// File: verif/miner_tb.sv
`timescale 1ns/1ps
`default_nettype none

module miner_tb;

    localparam int frame_cycles = 40;
    localparam int max_tests    = 16;
    localparam int max_items    = 5;
    localparam int fw           = miner_pkg::field_w;
    // longest single rope move, in clocks
    localparam int wait_limit   = 100 * frame_cycles;

    logic                                        clock;
    logic                                        resetn;
    logic                                        enable;
    logic                                        launch;
    logic                                        load_en;
    miner_pkg::item_idx_t                        load_index;
    miner_pkg::item_t                            load_item;
    logic [$bits(miner_pkg::item_idx_t):0]       item_count;
    logic                                        pause;
    logic [fw-1:0]                               angle;
    logic [fw-1:0]                               rope_len;
    logic [15:0]                                 score;
    logic [7:0]                                  catch_count;
    logic                                        item_visible;

    // test table, one row per data file line
    string  t_name    [max_tests];
    int     t_items   [max_tests];
    int     t_launch  [max_tests];
    int     t_delay   [max_tests];
    int     t_pause   [max_tests];
    int     t_score   [max_tests];
    int     t_count   [max_tests];
    int     t_vis     [max_tests];
    int     t_x       [max_tests][max_items];
    int     t_y       [max_tests][max_items];
    int     t_kind    [max_tests][max_items];
    int     n_tests;
    bit     data_ready;
    int     errors;
    int     checks;
    int     failed_tests;
    integer seed;

    miner_top #(
        .frame_cycles (frame_cycles)
    ) u_dut (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .launch       (launch),
        .load_en      (load_en),
        .load_index   (load_index),
        .load_item    (load_item),
        .item_count   (item_count),
        .pause        (pause),
        .angle        (angle),
        .rope_len     (rope_len),
        .score        (score),
        .catch_count  (catch_count),
        .item_visible (item_visible)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic check_score(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0s score: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] exp,
                               input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0s catch count: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_item(input string name, input logic exp_vis, input logic act_vis);
        checks++;
        if (act_vis !== exp_vis) begin
            errors++;
            $display("[FAIL] %0s item visible: expected %0b, actual %0b", name, exp_vis,
                     act_vis);
        end
    endtask

    task automatic check_rope(input string name, input string what,
                              input logic [fw-1:0] exp, input logic [fw-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0s %0s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic read_tests();
        int    fd;
        int    code;
        bit    done;
        string tok;
        string rest;
        fd = $fopen("verif/miner_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/miner_testdata.txt");
        end else begin
            done = 1'b0;
            while (!done && n_tests < max_tests) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tok.getc(0) == 8'h23) begin
                    code = $fgets(rest, fd);
                end else begin
                    t_name[n_tests] = tok;
                    code = $fscanf(fd, "%d %d %d %d %d %d %d", t_items[n_tests],
                                   t_launch[n_tests], t_delay[n_tests], t_pause[n_tests],
                                   t_score[n_tests], t_count[n_tests], t_vis[n_tests]);
                    for (int k = 0; k < max_items; k++) begin
                        code = $fscanf(fd, "%d %d %d", t_x[n_tests][k], t_y[n_tests][k],
                                       t_kind[n_tests][k]);
                    end
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_items(input int t);
        miner_pkg::item_t it;
        for (int k = 0; k < t_items[t]; k++) begin
            it.x       = fw'(t_x[t][k]);
            it.y       = fw'(t_y[t][k]);
            it.kind    = miner_pkg::item_kind_t'(t_kind[t][k]);
            it.visible = 1'b1;
            it.taken   = 1'b0;
            load_en    = 1'b1;
            load_index = miner_pkg::item_idx_t'(k);
            load_item  = it;
            @(posedge clock);
            #2;
        end
        load_en    = 1'b0;
        load_index = '0;
    endtask

    // leave = 1 waits for the rope to drop from the top, 0 for its return
    task automatic wait_rope(input string name, input bit leave, output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < wait_limit) begin
            @(posedge clock);
            #2;
            cycles++;
            ok = leave ? (rope_len != fw'(miner_pkg::rope_min_len)) :
                         (rope_len == fw'(miner_pkg::rope_min_len));
        end
        if (!ok) begin
            errors++;
            if (leave) begin
                $display("test %0s: the rope never left the top after a launch", name);
            end else begin
                $display("test %0s: the rope never came back to the top", name);
            end
        end
    endtask

    task automatic wait_count(input logic [7:0] target);
        int cycles;
        cycles = 0;
        while (catch_count != target && cycles < wait_limit) begin
            @(posedge clock);
            #2;
            cycles++;
        end
    endtask

    task automatic run_test(input int t);
        int            errs_before;
        int            extra;
        bit            ok;
        bit            going_left;
        logic [fw-1:0] exp_angle;
        errs_before = errors;
        resetn      = 1'b0;
        enable      = 1'b0;
        launch      = 1'b0;
        load_en     = 1'b0;
        load_index  = '0;
        pause       = (t_pause[t] != 0);
        item_count  = ($bits(item_count))'(t_items[t]);
        repeat (8) @(posedge clock);
        #2;
        resetn = 1'b1;
        @(posedge clock);
        #2;
        check_rope(t_name[t], "angle after reset", fw'(90), angle);
        check_rope(t_name[t], "length after reset", fw'(miner_pkg::rope_min_len), rope_len);
        load_items(t);
        enable = 1'b1;

        // one degree per tick, turning at the swing limits
        exp_angle  = fw'(90);
        going_left = 1'b1;
        for (int n = 0; n < t_delay[t]; n++) begin
            repeat (frame_cycles) @(posedge clock);
            #2;
            if (going_left && exp_angle == fw'(miner_pkg::swing_lo)) begin
                exp_angle  = exp_angle + 1'b1;
                going_left = 1'b0;
            end else if (!going_left && exp_angle == fw'(miner_pkg::swing_hi)) begin
                exp_angle  = exp_angle - 1'b1;
                going_left = 1'b1;
            end else if (going_left) begin
                exp_angle = exp_angle - 1'b1;
            end else begin
                exp_angle = exp_angle + 1'b1;
            end
            check_rope(t_name[t], "angle", exp_angle, angle);
        end

        // launch held until the rope drops, so it lands once the rope swings again
        for (int l = 0; l < t_launch[t]; l++) begin
            launch = 1'b1;
            wait_rope(t_name[t], 1'b1, ok);
            launch = 1'b0;
            if (ok) begin
                wait_rope(t_name[t], 1'b0, ok);
            end
        end

        if (t_pause[t] != 0) begin
            extra = $unsigned($random(seed)) % 8;
            repeat ((extra + 2) * frame_cycles) @(posedge clock);
            #2;
            check_count({t_name[t], " paused"}, 8'd0, catch_count);
            pause = 1'b0;
        end

        wait_count(8'(t_count[t]));
        repeat (2 * frame_cycles) @(posedge clock);
        #2;
        check_score(t_name[t], 16'(t_score[t]), score);
        check_count(t_name[t], 8'(t_count[t]), catch_count);
        check_item(t_name[t], t_vis[t] != 0, item_visible);

        if (errors == errs_before) begin
            $display("test %0s: ok", t_name[t]);
        end else begin
            failed_tests++;
            $display("test %0s: %0d errors", t_name[t], errors - errs_before);
        end
    endtask

    // watchdog sized from the number of tests
    initial begin
        wait (data_ready);
        repeat ((n_tests + 1) * 400 * frame_cycles) @(posedge clock);
        $display("timeout: the tests did not finish within %0d frame ticks",
                 (n_tests + 1) * 400);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        resetn       = 1'b0;
        enable       = 1'b0;
        launch       = 1'b0;
        load_en      = 1'b0;
        load_index   = '0;
        load_item    = '0;
        item_count   = '0;
        pause        = 1'b0;
        n_tests      = 0;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        seed         = 32'h1531_2114;
        data_ready   = 1'b0;
        read_tests();
        data_ready = 1'b1;
        @(posedge clock);
        #2;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, failed_tests,
                 checks, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/miner_testdata.txt
# name items launches delay_ticks pause score count visible0, then 5 items as x y kind
# kind 0 stone 1 gold 2 diamond; unused item slots are zero
reset_swing    1 0 90 0   0 0 1   40 150 0    0   0 0    0   0 0    0   0 0    0   0 0
empty_launch   0 1  0 0   0 0 0    0   0 0    0   0 0    0   0 0    0   0 0    0   0 0
catch_stone    1 1  0 0  10 1 0  152 100 0    0   0 0    0   0 0    0   0 0    0   0 0
catch_gold     1 1  0 0  20 1 0  152 100 1    0   0 0    0   0 0    0   0 0    0   0 0
catch_diamond  1 1  0 0  50 1 0  152 100 2    0   0 0    0   0 0    0   0 0    0   0 0
hide_item      1 2  0 0  20 1 0  152 100 1    0   0 0    0   0 0    0   0 0    0   0 0
back_pressure  5 5  0 1 110 5 0  152  60 0  152  90 1  152 120 2  152 150 1  152 180 0

// File: miner.f
common/miner_pkg.sv
common/catch_if.sv
rope/angle_trig.sv
rope/rope_ctrl.sv
design/item_table.sv
design/catch_fifo.sv
design/score_keeper.sv
design/miner_top.sv
verif/miner_chk.sv
verif/miner_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the miner testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module miner_tb -f miner.f \
    --Mdir obj_dir -o miner_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/miner_sim > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
